// ==== design/long_op_pkg.sv ====
// Long-latency operation encodings.
// Shared by the issue steering, both execution units and the testbench.
package long_op_pkg;

  // operation carried on the issue port.
  typedef enum logic [1:0] {
    OP_DIVU = 2'd0, // unsigned quotient.
    OP_REMU = 2'd1, // unsigned remainder.
    OP_SQRT = 2'd2, // floor of the square root.
    OP_MUL  = 2'd3  // low word of the product.
  } long_op_e;

  // result the divide/square-root core returns.
  typedef enum logic [1:0] {
    SEL_QUOT = 2'd0,
    SEL_REM  = 2'd1,
    SEL_ROOT = 2'd2
  } div_sqrt_sel_e;

endpackage

// ==== design/wb_pkg.sv ====
// Writeback arbitration definitions.
// Requester count and the fixed requester slot of each unit.
package wb_pkg;

  // units sharing the register-file write port.
  localparam int wb_req_count_gp = 2;

  // requester slots on the arbiter.
  localparam int wb_req_divsqrt_gp = 0;
  localparam int wb_req_mul_gp     = 1;

endpackage

// ==== design/div_sqrt_core.sv ====
// Iterative divide / square-root core.
// Radix-2 restoring division and bitwise integer square root on one
// remainder register, one shifter and one subtractor.
`timescale 1ns/1ps

module div_sqrt_core
  import long_op_pkg::*;
#(
  parameter int data_width_p = 16
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    v_i,
  input  div_sqrt_sel_e           sel_i,
  input  logic [data_width_p-1:0] a_i,
  input  logic [data_width_p-1:0] b_i,
  output logic                    ready_o,
  output logic                    v_o,
  output logic [data_width_p-1:0] result_o
);

  localparam int cnt_width_lp = $clog2(data_width_p) + 1;

  logic                    busy_r;
  logic                    v_r;
  div_sqrt_sel_e           sel_r;
  logic [cnt_width_lp-1:0] cnt_r;   // steps left.
  logic [data_width_p-1:0] rem_r;   // partial remainder.
  logic [data_width_p-1:0] shift_r; // operand bits out, quotient bits in.
  logic [data_width_p-1:0] div_r;   // divisor, or the root so far.

  logic                    is_sqrt;
  logic                    accept;
  logic [data_width_p:0]   trial_a;
  logic [data_width_p:0]   trial_b;
  logic [data_width_p+1:0] diff;
  logic                    fits;

  assign is_sqrt = (sel_r == SEL_ROOT);
  assign accept  = v_i & ready_o;
  assign ready_o = ~busy_r;
  assign v_o     = v_r;

  // trial subtraction operands
  always_comb begin
    if (is_sqrt) begin
      trial_a = {rem_r[data_width_p-2:0], shift_r[data_width_p-1 -: 2]}; // two radicand bits.
      trial_b = {div_r[data_width_p-2:0], 2'b01};
    end else begin
      trial_a = {rem_r, shift_r[data_width_p-1]};
      trial_b = {1'b0, div_r};
    end
  end

  assign diff = {1'b0, trial_a} - {1'b0, trial_b};
  assign fits = ~diff[data_width_p+1]; // no borrow.

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
      v_r    <= 1'b0;
      sel_r  <= SEL_QUOT;
      cnt_r  <= '0;
    end else begin
      v_r <= 1'b0;
      if (accept) begin
        sel_r <= sel_i;
        if (sel_i != SEL_ROOT && b_i == '0) begin
          v_r <= 1'b1; // zero divisor finishes at once.
        end else begin
          busy_r <= 1'b1;
          cnt_r  <= (sel_i == SEL_ROOT) ? cnt_width_lp'(data_width_p / 2)
                                        : cnt_width_lp'(data_width_p);
        end
      end else if (busy_r) begin
        cnt_r <= cnt_r - 1'b1;
        if (cnt_r == cnt_width_lp'(1)) begin
          busy_r <= 1'b0;
          v_r    <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rem_r   <= (sel_i != SEL_ROOT && b_i == '0) ? a_i : '0; // riscv: rem is the dividend.
      shift_r <= (sel_i != SEL_ROOT && b_i == '0) ? '1 : a_i;  // riscv: quotient all ones.
      div_r   <= (sel_i == SEL_ROOT) ? '0 : b_i;
    end else if (busy_r) begin
      rem_r <= fits ? diff[data_width_p-1:0] : trial_a[data_width_p-1:0];
      if (is_sqrt) begin
        shift_r <= {shift_r[data_width_p-3:0], 2'b00};
        div_r   <= {div_r[data_width_p-2:0], fits};
      end else begin
        shift_r <= {shift_r[data_width_p-2:0], fits};
      end
    end
  end

  always_comb begin
    case (sel_r)
      SEL_REM:  result_o = rem_r;
      SEL_ROOT: result_o = div_r;
      default:  result_o = shift_r;
    endcase
  end

endmodule

// ==== design/div_sqrt_unit.sv ====
// Divide / square-root execution unit.
// Idle/busy/done control around the iterative core, with tag capture
// and a result held for the writeback arbiter until yumi.
`timescale 1ns/1ps

module div_sqrt_unit
  import long_op_pkg::*;
#(
  parameter int data_width_p     = 16,
  parameter int reg_addr_width_p = 5
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        v_i,
  input  long_op_e                    op_i,
  input  logic [reg_addr_width_p-1:0] rd_i,
  input  logic [data_width_p-1:0]     rs1_i,
  input  logic [data_width_p-1:0]     rs2_i,
  input  logic                        yumi_i,
  output logic                        ready_o,
  output logic                        v_o,
  output logic [reg_addr_width_p-1:0] rd_o,
  output logic [data_width_p-1:0]     result_o
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } state_e;

  state_e                      state_r;
  state_e                      state_n;
  logic [reg_addr_width_p-1:0] rd_r;
  logic                        core_ready;
  logic                        core_v_li;
  logic                        core_v_lo;
  div_sqrt_sel_e               sel;

  always_comb begin
    case (op_i)
      OP_REMU: sel = SEL_REM;
      OP_SQRT: sel = SEL_ROOT;
      default: sel = SEL_QUOT;
    endcase
  end

  div_sqrt_core #(
    .data_width_p(data_width_p)
  ) core (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(core_v_li),
    .sel_i(sel),
    .a_i(rs1_i),
    .b_i(rs2_i),
    .ready_o(core_ready),
    .v_o(core_v_lo),
    .result_o(result_o) // stable until the next accept.
  );

  always_comb begin
    state_n   = state_r;
    ready_o   = 1'b0;
    core_v_li = 1'b0;
    v_o       = 1'b0;
    case (state_r)
      IDLE: begin
        ready_o   = core_ready;
        core_v_li = v_i;
        if (v_i && core_ready) state_n = BUSY;
      end
      BUSY: begin
        if (core_v_lo) begin // core pulses once.
          v_o     = 1'b1;
          state_n = yumi_i ? IDLE : DONE;
        end
      end
      DONE: begin
        v_o     = 1'b1;
        state_n = yumi_i ? IDLE : DONE;
      end
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) state_r <= IDLE;
    else state_r <= state_n;
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && v_i) rd_r <= rd_i; // tag follows the op.
  end

  assign rd_o = rd_r;

endmodule

// ==== design/mul_unit.sv ====
// Shift-add multiplier unit.
// One partial product per cycle into a low-word accumulator, with the
// same idle/busy/done handshake and tag capture as the divide unit.
`timescale 1ns/1ps

module mul_unit #(
  parameter int data_width_p     = 16,
  parameter int reg_addr_width_p = 5
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        v_i,
  input  logic [reg_addr_width_p-1:0] rd_i,
  input  logic [data_width_p-1:0]     rs1_i,
  input  logic [data_width_p-1:0]     rs2_i,
  input  logic                        yumi_i,
  output logic                        ready_o,
  output logic                        v_o,
  output logic [reg_addr_width_p-1:0] rd_o,
  output logic [data_width_p-1:0]     result_o
);

  localparam int cnt_width_lp = $clog2(data_width_p) + 1;

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } state_e;

  state_e                      state_r;
  logic [cnt_width_lp-1:0]     cnt_r;
  logic [data_width_p-1:0]     mcand_r;  // shifts left each step.
  logic [data_width_p-1:0]     mplier_r; // shifts right each step.
  logic [data_width_p-1:0]     acc_r;
  logic [reg_addr_width_p-1:0] rd_r;

  assign ready_o  = (state_r == IDLE);
  assign v_o      = (state_r == DONE);
  assign rd_o     = rd_r;
  assign result_o = acc_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        IDLE: begin
          if (v_i) begin
            state_r <= BUSY;
            cnt_r   <= cnt_width_lp'(data_width_p);
          end
        end
        BUSY: begin
          cnt_r <= cnt_r - 1'b1;
          if (cnt_r == cnt_width_lp'(1)) state_r <= DONE;
        end
        DONE:    if (yumi_i) state_r <= IDLE;
        default: state_r <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && v_i) begin
      mcand_r  <= rs1_i;
      mplier_r <= rs2_i;
      acc_r    <= '0;
      rd_r     <= rd_i;
    end else if (state_r == BUSY) begin
      if (mplier_r[0]) acc_r <= acc_r + mcand_r; // carries above the low word drop out.
      mcand_r  <= mcand_r << 1;
      mplier_r <= mplier_r >> 1;
    end
  end

endmodule

// ==== design/wb_arbiter.sv ====
// Round-robin writeback arbiter.
// Grants the single register-file write port to one unit at a time and
// keeps a pending grant fixed while the port is stalled.
`timescale 1ns/1ps

module wb_arbiter
  import wb_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [wb_req_count_gp-1:0] req_i,
  input  logic                       wb_ready_i,
  output logic [wb_req_count_gp-1:0] grant_o,
  output logic [wb_req_count_gp-1:0] yumi_o
);

  localparam int idx_width_lp = $clog2(wb_req_count_gp);

  logic [idx_width_lp-1:0] last_r;     // last requester served.
  logic [idx_width_lp-1:0] hold_idx_r;
  logic                    hold_r;     // grant given but not yet taken.
  logic [idx_width_lp-1:0] win_idx;
  logic                    found;

  // search starts just after the last served requester
  always_comb begin
    win_idx = last_r;
    found   = 1'b0;
    for (int i = 1; i <= wb_req_count_gp; i++) begin
      if (!found && req_i[(int'(last_r) + i) % wb_req_count_gp]) begin
        win_idx = idx_width_lp'((int'(last_r) + i) % wb_req_count_gp);
        found   = 1'b1;
      end
    end
    if (hold_r) begin
      win_idx = hold_idx_r; // data must not change under a stall.
      found   = req_i[hold_idx_r];
    end
  end

  assign grant_o = wb_req_count_gp'(found) << win_idx;
  assign yumi_o  = grant_o & {wb_req_count_gp{wb_ready_i}};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_r     <= idx_width_lp'(wb_req_mul_gp); // divide side wins the first conflict.
      hold_r     <= 1'b0;
      hold_idx_r <= '0;
    end else begin
      hold_r     <= found & ~wb_ready_i;
      hold_idx_r <= win_idx;
      if (found && wb_ready_i) last_r <= win_idx;
    end
  end

endmodule

// ==== design/long_op_top.sv ====
// Long-latency execution block.
// Steers each issued op to the divide/sqrt unit or the multiplier and
// merges their results onto one writeback port through the arbiter.
`timescale 1ns/1ps

module long_op_top
  import long_op_pkg::*;
  import wb_pkg::*;
#(
  parameter int data_width_p     = 16,
  parameter int reg_addr_width_p = 5
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        v_i,
  input  long_op_e                    op_i,
  input  logic [reg_addr_width_p-1:0] rd_i,
  input  logic [data_width_p-1:0]     rs1_i,
  input  logic [data_width_p-1:0]     rs2_i,
  output logic                        ready_o,
  output logic                        wb_v_o,
  output logic [reg_addr_width_p-1:0] wb_rd_o,
  output logic [data_width_p-1:0]     wb_data_o,
  input  logic                        wb_ready_i
);

  logic                        is_mul;
  logic                        div_ready, mul_ready;
  logic [reg_addr_width_p-1:0] div_rd, mul_rd;
  logic [data_width_p-1:0]     div_result, mul_result;
  logic [wb_req_count_gp-1:0]  req, grant, yumi;

  assign is_mul  = (op_i == OP_MUL);
  assign ready_o = is_mul ? mul_ready : div_ready; // owner's ready only.

  div_sqrt_unit #(
    .data_width_p(data_width_p),
    .reg_addr_width_p(reg_addr_width_p)
  ) div_sqrt (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(v_i & ~is_mul), .op_i(op_i), .rd_i(rd_i), .rs1_i(rs1_i), .rs2_i(rs2_i),
    .yumi_i(yumi[wb_req_divsqrt_gp]), .ready_o(div_ready),
    .v_o(req[wb_req_divsqrt_gp]), .rd_o(div_rd), .result_o(div_result)
  );

  mul_unit #(
    .data_width_p(data_width_p),
    .reg_addr_width_p(reg_addr_width_p)
  ) mul (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(v_i & is_mul), .rd_i(rd_i), .rs1_i(rs1_i), .rs2_i(rs2_i),
    .yumi_i(yumi[wb_req_mul_gp]), .ready_o(mul_ready),
    .v_o(req[wb_req_mul_gp]), .rd_o(mul_rd), .result_o(mul_result)
  );

  wb_arbiter arb (
    .clk_i(clk_i), .reset_i(reset_i),
    .req_i(req), .wb_ready_i(wb_ready_i),
    .grant_o(grant), .yumi_o(yumi)
  );

  assign wb_v_o    = |req;
  assign wb_rd_o   = grant[wb_req_mul_gp] ? mul_rd : div_rd;
  assign wb_data_o = grant[wb_req_mul_gp] ? mul_result : div_result;

endmodule

// ==== sim/long_op_assertions.sv ====
// Handshake assertions for the long-latency execution block.
// Bound into the top level, watching the issue and writeback ports.
`timescale 1ns/1ps

module long_op_assertions
  import wb_pkg::*;
#(
  parameter int data_width_p     = 16,
  parameter int reg_addr_width_p = 5
) (
  input logic                        clk_i,
  input logic                        reset_i,
  input logic                        ready_o,
  input logic                        wb_v_o,
  input logic                        wb_ready_i,
  input logic [reg_addr_width_p-1:0] wb_rd_o,
  input logic [data_width_p-1:0]     wb_data_o,
  input logic [wb_req_count_gp-1:0]  req_i,
  input logic [wb_req_count_gp-1:0]  grant_i
);

  int fail_cnt = 0;

  logic [wb_req_count_gp-1:0] served_r; // requester of the last transfer.

  always_ff @(posedge clk_i) begin
    if (reset_i) served_r <= '0;
    else if (wb_v_o && wb_ready_i) served_r <= grant_i;
  end

  // a stalled result keeps its tag and data.
  wb_hold_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (wb_v_o && !wb_ready_i) |=> (wb_v_o && $stable(wb_rd_o) && $stable(wb_data_o))
  ) else begin
    fail_cnt++;
    $error("writeback tag or data changed while the port was stalled");
  end

  // both units come out of reset idle.
  reset_idle: assert property (
    @(posedge clk_i) $fell(reset_i) |-> (!wb_v_o && ready_o)
  ) else begin
    fail_cnt++;
    $error("writeback valid high or issue ready low right after reset");
  end

  // a fresh conflict goes to the unit that was not served last.
  rr_alternate: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (&req_i && !$past(wb_v_o && !wb_ready_i)) |-> (grant_i != served_r)
  ) else begin
    fail_cnt++;
    $error("arbiter granted the same unit twice in a row on a conflict");
  end

endmodule

bind long_op_top long_op_assertions #(
  .data_width_p(data_width_p),
  .reg_addr_width_p(reg_addr_width_p)
) handshake_checks (
  .clk_i(clk_i), .reset_i(reset_i), .ready_o(ready_o),
  .wb_v_o(wb_v_o), .wb_ready_i(wb_ready_i), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
  .req_i(req), .grant_i(grant)
);

// ==== sim/long_op_checker.sv ====
// Writeback scoreboard for the long-latency execution block.
// Records the expected result per tag at issue and compares it with
// each writeback transfer, one report line per finished op.
`timescale 1ns/1ps

module long_op_checker
  import long_op_pkg::*;
#(
  parameter int data_width_p     = 16,
  parameter int reg_addr_width_p = 5
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        v_i,
  input  logic                        ready_i,
  input  long_op_e                    op_i,
  input  logic [reg_addr_width_p-1:0] rd_i,
  input  logic [data_width_p-1:0]     exp_i,
  input  logic                        wb_v_i,
  input  logic                        wb_ready_i,
  input  logic [reg_addr_width_p-1:0] wb_rd_i,
  input  logic [data_width_p-1:0]     wb_data_i,
  output int                          pass_cnt_o,
  output int                          err_cnt_o,
  output int                          done_cnt_o
);

  localparam int tags_lp = 1 << reg_addr_width_p;

  logic [data_width_p-1:0] exp_mem [tags_lp];
  long_op_e                op_mem  [tags_lp];
  logic                    pending [tags_lp]; // op issued, result not back yet.

  always @(posedge clk_i) begin
    if (reset_i) begin
      pass_cnt_o = 0;
      err_cnt_o  = 0;
      done_cnt_o = 0;
      for (int i = 0; i < tags_lp; i++) pending[i] = 1'b0;
    end else begin
      // retire first, so a tag can be reused in the same cycle.
      if (wb_v_i && wb_ready_i) begin
        done_cnt_o++;
        if (!pending[wb_rd_i]) begin
          $display("writeback to tag %0d, which has no operation pending", wb_rd_i);
          err_cnt_o++;
        end else if (wb_data_i !== exp_mem[wb_rd_i]) begin
          $display("ERR wb_data_o tag %0d %s: expected %h got %h",
                   wb_rd_i, op_mem[wb_rd_i].name(), exp_mem[wb_rd_i], wb_data_i);
          err_cnt_o++;
        end else begin
          $display("ok  tag %0d %s = %h", wb_rd_i, op_mem[wb_rd_i].name(), wb_data_i);
          pass_cnt_o++;
        end
        pending[wb_rd_i] = 1'b0;
      end
      if (v_i && ready_i) begin
        if (pending[rd_i]) begin
          $display("tag %0d issued again before its result came back", rd_i);
          err_cnt_o++;
        end
        exp_mem[rd_i] = exp_i;
        op_mem[rd_i]  = op_i;
        pending[rd_i] = 1'b1;
      end
    end
  end

endmodule

// ==== sim/long_op_tb.sv ====
// Testbench for the long-latency execution block.
// Runs a table of directed and random ops through the issue port while
// the writeback port stalls on random cycles and in one long window.
`timescale 1ns/1ps

module long_op_tb
  import long_op_pkg::*;
();

  localparam int data_width_lp     = 16;
  localparam int reg_addr_width_lp = 5;
  localparam int directed_lp       = 17;
  localparam int entries_lp        = 30;
  localparam int hold_row_lp       = 14; // multiply whose result is held back.
  localparam int stall_row_lp      = 16; // next multiply, must wait for it.
  localparam int hold_cycles_lp    = 80;
  localparam int timeout_lp        = entries_lp * (2 * data_width_lp + 20);

  logic                         clk_i;
  logic                         reset_i;
  logic                         v_i;
  long_op_e                     op_i;
  logic [reg_addr_width_lp-1:0] rd_i;
  logic [data_width_lp-1:0]     rs1_i;
  logic [data_width_lp-1:0]     rs2_i;
  logic [data_width_lp-1:0]     exp_r; // expected result of the op on the port.
  logic                         ready_o;
  logic                         wb_v_o;
  logic [reg_addr_width_lp-1:0] wb_rd_o;
  logic [data_width_lp-1:0]     wb_data_o;
  logic                         wb_ready_i = 1'b1;
  logic [31:0]                  wb_rng;
  int                           cycle_cnt = 0;
  int                           hold_until = 0;
  int                           tb_errs = 0;
  int                           pass_cnt;
  int                           err_cnt;
  int                           done_cnt;

  long_op_e                     tab_op  [entries_lp];
  logic [reg_addr_width_lp-1:0] tab_rd  [entries_lp];
  logic [data_width_lp-1:0]     tab_a   [entries_lp];
  logic [data_width_lp-1:0]     tab_b   [entries_lp];
  logic [data_width_lp-1:0]     tab_exp [entries_lp];

  long_op_top #(
    .data_width_p(data_width_lp),
    .reg_addr_width_p(reg_addr_width_lp)
  ) UUT (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(v_i), .op_i(op_i), .rd_i(rd_i), .rs1_i(rs1_i), .rs2_i(rs2_i), .ready_o(ready_o),
    .wb_v_o(wb_v_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o), .wb_ready_i(wb_ready_i)
  );

  long_op_checker #(
    .data_width_p(data_width_lp),
    .reg_addr_width_p(reg_addr_width_lp)
  ) scoreboard (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(v_i), .ready_i(ready_o), .op_i(op_i), .rd_i(rd_i), .exp_i(exp_r),
    .wb_v_i(wb_v_o), .wb_ready_i(wb_ready_i), .wb_rd_i(wb_rd_o), .wb_data_i(wb_data_o),
    .pass_cnt_o(pass_cnt), .err_cnt_o(err_cnt), .done_cnt_o(done_cnt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // arithmetic reference, straight from the operation definitions.
  function automatic logic [data_width_lp-1:0] ref_result(input long_op_e op,
      input logic [data_width_lp-1:0] a, input logic [data_width_lp-1:0] b);
    longint unsigned x;
    longint unsigned y;
    longint unsigned r;
    x = a;
    y = b;
    r = 0;
    case (op)
      OP_DIVU: r = (y == 0) ? (64'd1 << data_width_lp) - 1 : x / y;
      OP_REMU: r = (y == 0) ? x : x % y;
      OP_SQRT: while ((r + 1) * (r + 1) <= x) r++;
      default: r = x * y;
    endcase
    return data_width_lp'(r);
  endfunction

  task automatic set_row(input int idx, input long_op_e op,
      input logic [data_width_lp-1:0] a, input logic [data_width_lp-1:0] b);
    tab_op[idx]  = op;
    tab_rd[idx]  = reg_addr_width_lp'(idx % 31 + 1); // neighbours never share a tag.
    tab_a[idx]   = a;
    tab_b[idx]   = b;
    tab_exp[idx] = ref_result(op, a, b);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // random back-pressure, forced low inside the hold window.
  always @(posedge clk_i) begin
    if (reset_i) begin
      wb_rng     <= 32'd73150;
      wb_ready_i <= 1'b1;
    end else begin
      wb_rng     <= xorshift32(wb_rng);
      wb_ready_i <= (cycle_cnt < hold_until) ? 1'b0 : (wb_rng[1:0] != 2'd0);
    end
  end

  initial begin
    wait (cycle_cnt >= timeout_lp);
    $display("timeout after %0d cycles with %0d of %0d results written back",
             cycle_cnt, done_cnt, entries_lp);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [31:0] rng;
    rng     = 32'd73150;
    reset_i = 1'b1;
    v_i     = 1'b0;
    op_i    = OP_DIVU;
    rd_i    = '0;
    rs1_i   = '0;
    rs2_i   = '0;
    exp_r   = '0;
    set_row(0,  OP_DIVU, 16'd100,  16'd7);
    set_row(1,  OP_REMU, 16'd100,  16'd7);
    set_row(2,  OP_DIVU, 16'd5,    16'd9); // divisor above dividend.
    set_row(3,  OP_REMU, 16'd5,    16'd9);
    set_row(4,  OP_DIVU, 16'hbeef, 16'h0);
    set_row(5,  OP_REMU, 16'hbeef, 16'h0);
    set_row(6,  OP_SQRT, 16'd0,    16'd0);
    set_row(7,  OP_SQRT, 16'd144,  16'd0);
    set_row(8,  OP_SQRT, 16'd65025, 16'd0);
    set_row(9,  OP_SQRT, 16'hffff, 16'd0);
    set_row(10, OP_MUL,  16'd300,  16'd300);
    set_row(11, OP_MUL,  16'hffff, 16'hffff);
    set_row(12, OP_MUL,  16'h1234, 16'h5678); // back to back with the divide.
    set_row(13, OP_DIVU, 16'hfff0, 16'h0013);
    set_row(14, OP_MUL,  16'h00ff, 16'h0101);
    set_row(15, OP_REMU, 16'habcd, 16'h0123);
    set_row(16, OP_MUL,  16'h0007, 16'h0009);
    for (int i = directed_lp; i < entries_lp; i++) begin
      rng = xorshift32(rng);
      tab_op[i] = long_op_e'(rng[1:0]);
      tab_a[i]  = rng[31:16];
      rng = xorshift32(rng);
      set_row(i, tab_op[i], tab_a[i], rng[15:0] >> rng[19:16]); // mix of divisor sizes.
    end

    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    for (int i = 0; i < entries_lp; i++) begin
      v_i   <= 1'b1;
      op_i  <= tab_op[i];
      rd_i  <= tab_rd[i];
      rs1_i <= tab_a[i];
      rs2_i <= tab_b[i];
      exp_r <= tab_exp[i];
      do @(posedge clk_i); while (!ready_o);
      if (i == hold_row_lp) hold_until <= cycle_cnt + hold_cycles_lp;
      if (i == stall_row_lp && cycle_cnt < hold_until) begin
        $display("multiply was accepted while the previous multiply result was still held");
        tb_errs++;
      end
    end
    v_i <= 1'b0;

    wait (done_cnt >= entries_lp);
    repeat (4) @(posedge clk_i);
    tb_errs = tb_errs + UUT.handshake_checks.fail_cnt;
    $display("tests: %0d passed, %0d failed, %0d other errors", pass_cnt, err_cnt, tb_errs);
    if (err_cnt == 0 && tb_errs == 0 && pass_cnt == entries_lp) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== long_op.f ====
design/long_op_pkg.sv
design/wb_pkg.sv
design/div_sqrt_core.sv
design/div_sqrt_unit.sv
design/mul_unit.sv
design/wb_arbiter.sv
design/long_op_top.sv
sim/long_op_assertions.sv
sim/long_op_checker.sv
sim/long_op_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the long-op testbench with Verilator, run it, and check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module long_op_tb -f long_op.f -o long_op_sim

# the simulation keeps running past assertion errors so the testbench can report them
./obj_dir/long_op_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

grep -q "^RESULT: PASS$" sim.log
